// ==== rx_audio_top.f ====
design/rx_pkg.sv
design/rx_buf_if.sv
design/rx_frame_seq.sv
design/rx_sample_buf.sv
design/rx_host_port.sv
design/rx_audio_top.sv
testbench/rx_audio_asserts.sv
testbench/tb_rx_audio.sv

// ==== Makefile ====
# Verilator build and run for the receiver audio path

VERILATOR ?= verilator
TOP       ?= tb_rx_audio
FILELIST  ?= rx_audio_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_rx_audio.sv ====
////////////////////////////////////////
// receiver audio path testbench
////////////////////////////////////////
`timescale 1ns/1ns

module tb_rx_audio;
	import rx_pkg::*;

	localparam int CLK_NS      = 8;
	localparam int NUM_BUFS    = 48;    // enough words to wrap the 1024 word buffer
	localparam int MAX_NSAMPS  = 5;
	localparam int GAP_MIN     = 22;    // avail spacing stays above 20 cycles
	localparam int GAP_SPAN    = 8;
	localparam int SRQ_WAIT    = 64;    // cycles from last frame to srq
	localparam int MAX_WORDS   = WORDS_PER_CHAN * N_CHANS * MAX_NSAMPS + TICK_WORDS + 1;
	localparam int BUF_CYCLES  = MAX_NSAMPS * (GAP_MIN + GAP_SPAN + 2)
		+ 2 * (MAX_WORDS + 2) + SRQ_WAIT;
	localparam int WATCHDOG_NS = (NUM_BUFS + 2) * BUF_CYCLES * CLK_NS;

	logic      adc_clk;
	logic      reset_bufs_A;
	logic      avail_i;
	chan_bus_t chan_i;
	ticks_t    ticks_i;
	logic      set_nsamps_i;
	nsamps_t   nsamps_i;
	logic      rd_samp_i;
	logic      rd_ctr_i;
	logic      srq_ack_i;
	logic      rd_valid_o;
	word_t     rd_data_o;
	logic      srq_o;

	// model state
	word_t    exp_q[$];       // words the next buffer should hold, in read order
	buf_ctr_t exp_ctr;        // completed buffers so far
	int       words_total;    // sample words read since power-up
	word_t    rd_val;
	int       b;

	rx_audio_top dut_i (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.avail_i      (avail_i),
		.chan_i       (chan_i),
		.ticks_i      (ticks_i),
		.set_nsamps_i (set_nsamps_i),
		.nsamps_i     (nsamps_i),
		.rd_samp_i    (rd_samp_i),
		.rd_ctr_i     (rd_ctr_i),
		.srq_ack_i    (srq_ack_i),
		.rd_valid_o   (rd_valid_o),
		.rd_data_o    (rd_data_o),
		.srq_o        (srq_o)
	);

	initial adc_clk = 1'b0;
	always #(CLK_NS / 2) adc_clk = ~adc_clk;

	////////////////////////////////////////
	// result checks

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_word(input word_t got, input word_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: buffer word got %h, expected %h", $time, got, exp));
	endtask

	task automatic check_ctr(input buf_ctr_t got, input buf_ctr_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: buffer counter got %0d, expected %0d",
				$time, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: %s got %b, expected %b", $time, what, got, exp));
	endtask

	////////////////////////////////////////
	// drivers

	task automatic release_reset();
		repeat (3) @(posedge adc_clk);
		reset_bufs_A <= 1'b0;     // high for 3 sampled edges
	endtask

	task automatic pulse_reset();
		@(posedge adc_clk);
		reset_bufs_A <= 1'b1;
		release_reset();
	endtask

	// one read strobe, valid expected exactly one cycle later
	task automatic do_read(input bit ctr, output word_t data);
		@(posedge adc_clk);
		if (ctr)
			rd_ctr_i <= 1'b1;
		else
			rd_samp_i <= 1'b1;
		@(negedge adc_clk);
		check_bit(rd_valid_o, 1'b0, "rd_valid_o in the strobe cycle");
		@(posedge adc_clk);
		rd_ctr_i  <= 1'b0;
		rd_samp_i <= 1'b0;
		@(negedge adc_clk);
		check_bit(rd_valid_o, 1'b1, "rd_valid_o one cycle after the strobe");
		data = rd_data_o;
	endtask

	// random frame, expected words pushed in interleave order
	task automatic send_frame(input bit last);
		chan_bus_t cb;
		ticks_t    tk;
		word_t     w;
		for (int c = 0; c < N_CHANS; c++)
			for (int k = 0; k < WORDS_PER_CHAN; k++)
			begin
				w = word_t'($urandom);
				cb[(c * WORDS_PER_CHAN + k) * WORD_W +: WORD_W] = w;
				exp_q.push_back(w);     // i, q, iq3 of each channel
			end
		tk = ticks_t'({$urandom, $urandom});
		@(posedge adc_clk);
		avail_i <= 1'b1;
		chan_i  <= cb;
		ticks_i <= tk;
		@(posedge adc_clk);
		avail_i <= 1'b0;
		if (last)
		begin
			for (int t = 0; t < TICK_WORDS; t++)
				exp_q.push_back(tk[t * WORD_W +: WORD_W]);   // low word first
			exp_q.push_back(exp_ctr);   // count before the increment
		end
	endtask

	// one whole buffer, written, then read back and acknowledged if read_back is set
	task automatic run_buffer(input bit read_back);
		int    n;
		int    cnt;
		word_t data;
		n = 1 + int'($urandom % MAX_NSAMPS);
		@(posedge adc_clk);
		set_nsamps_i <= 1'b1;
		nsamps_i     <= nsamps_t'(n);
		@(posedge adc_clk);
		set_nsamps_i <= 1'b0;
		for (int f = 0; f < n; f++)
		begin
			send_frame(f == n - 1);
			if (f < n - 1)
				repeat (GAP_MIN + int'($urandom % GAP_SPAN)) @(posedge adc_clk);
		end
		@(negedge adc_clk);
		check_bit(srq_o, 1'b0, "srq_o before the buffer completes");
		cnt = 0;
		while (srq_o !== 1'b1)
		begin
			@(negedge adc_clk);
			cnt++;
			if (cnt > SRQ_WAIT)
				fail_run("timeout: no service request after the last frame of a buffer");
		end
		if (!read_back)
		begin
			exp_q.delete();     // stays in the buffer, srq left pending
			return;
		end
		while (exp_q.size() > 0)
		begin
			do_read(1'b0, data);
			check_word(data, exp_q.pop_front());
			words_total++;
		end
		check_bit(srq_o, 1'b1, "srq_o held until acknowledged");
		exp_ctr++;
		do_read(1'b1, data);
		check_ctr(buf_ctr_t'(data), exp_ctr);
		@(posedge adc_clk);
		srq_ack_i <= 1'b1;
		@(posedge adc_clk);
		srq_ack_i <= 1'b0;
		@(negedge adc_clk);
		check_bit(srq_o, 1'b0, "srq_o after srq_ack_i");
	endtask

	////////////////////////////////////////
	// main sequence

	initial
	begin
		void'($urandom(32'haa8a));
		reset_bufs_A = 1'b1;
		avail_i      = 1'b0;
		chan_i       = '0;
		ticks_i      = '0;
		set_nsamps_i = 1'b0;
		nsamps_i     = '0;
		rd_samp_i    = 1'b0;
		rd_ctr_i     = 1'b0;
		srq_ack_i    = 1'b0;
		exp_ctr      = '0;
		words_total  = 0;
		release_reset();
		@(negedge adc_clk);
		check_bit(rd_valid_o, 1'b0, "rd_valid_o after reset");
		check_bit(srq_o, 1'b0, "srq_o after reset");
		do_read(1'b1, rd_val);
		check_ctr(buf_ctr_t'(rd_val), '0);
		for (b = 0; b < NUM_BUFS; b++)
			run_buffer(1'b1);
		if (words_total <= BUF_WORDS)
			fail_run("too few words were written for the buffer pointers to wrap");
		// unread buffer and pending srq, so the reset has something to clear
		run_buffer(1'b0);
		// mid-run reset, counter and pointers start over
		pulse_reset();
		exp_ctr = '0;
		@(negedge adc_clk);
		check_bit(srq_o, 1'b0, "srq_o after the reset pulse");
		do_read(1'b1, rd_val);
		check_ctr(buf_ctr_t'(rd_val), '0);
		run_buffer(1'b1);
		$display("All checks passed");
		$finish;
	end

	// watchdog, sized from the buffer count and the longest buffer
	initial
	begin
		#(WATCHDOG_NS);
		fail_run($sformatf("timeout: run did not finish within %0d ns", WATCHDOG_NS));
	end

endmodule

// ==== testbench/rx_audio_asserts.sv ====
////////////////////////////////////////
// sequencer and buffer assertions
////////////////////////////////////////
`timescale 1ns/1ns

module rx_audio_asserts #(
	parameter bit SEQ_SIDE = 1'b1     // 1 on the sequencer, 0 on the buffer
) (
	input logic          adc_clk,
	input logic          reset_bufs_A,
	input logic          wr,
	input logic          buf_done,
	input logic          in_idle,
	input logic          start,       // frame accepted, writes begin next cycle
	input rx_pkg::addr_t waddr
);
	if (SEQ_SIDE)
	begin : g_seq
		// an idle cycle without an accepted frame keeps the write port quiet
		a_no_wr_idle: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
			in_idle && !start |=> !wr)
			else $error("write strobe after S_IDLE without an accepted frame");
		a_done_pulse: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
			buf_done |=> !buf_done) else $error("buf_done longer than one cycle");
	end
	else
	begin : g_buf
		// pointer moves on exactly the write cycles
		a_ptr_step: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
			wr |=> waddr == rx_pkg::addr_t'($past(waddr) + 1'b1))
			else $error("write pointer missed a write");
		a_ptr_hold: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
			!wr |=> waddr == $past(waddr)) else $error("write pointer moved without a write");
	end

endmodule

bind rx_frame_seq rx_audio_asserts #(.SEQ_SIDE(1'b1)) seq_chk (
	.adc_clk      (adc_clk),
	.reset_bufs_A (reset_bufs_A),
	.wr           (wr_o),
	.buf_done     (buf_done_o),
	.in_idle      (state == rx_pkg::S_IDLE),
	.start        (start),
	.waddr        ('0)
);

bind rx_sample_buf rx_audio_asserts #(.SEQ_SIDE(1'b0)) buf_chk (
	.adc_clk      (adc_clk),
	.reset_bufs_A (reset_bufs_A),
	.wr           (wr_i),
	.buf_done     (buf_done_i),
	.in_idle      (1'b0),
	.start        (1'b0),
	.waddr        (waddr)
);

// ==== design/rx_audio_top.sv ====
////////////////////////////////////////
// receiver audio sample path
////////////////////////////////////////
`timescale 1ns/1ns

module rx_audio_top (
	input  logic              adc_clk,
	input  logic              reset_bufs_A,
	input  logic              avail_i,
	input  rx_pkg::chan_bus_t chan_i,
	input  rx_pkg::ticks_t    ticks_i,
	input  logic              set_nsamps_i,
	input  rx_pkg::nsamps_t   nsamps_i,
	input  logic              rd_samp_i,
	input  logic              rd_ctr_i,
	input  logic              srq_ack_i,
	output logic              rd_valid_o,
	output rx_pkg::word_t     rd_data_o,
	output logic              srq_o
);
	import rx_pkg::*;

	logic  wr;          // sequencer write strobe
	word_t wdata;
	logic  buf_done;

	rx_buf_if buf_if ();   // buffer to host read path

	// producer, interleaves channels then ticks and counter
	rx_frame_seq frame_seq_i (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.avail_i      (avail_i),
		.chan_i       (chan_i),
		.ticks_i      (ticks_i),
		.set_nsamps_i (set_nsamps_i),
		.nsamps_i     (nsamps_i),
		.wr_o         (wr),
		.wdata_o      (wdata),
		.buf_done_o   (buf_done),
		.buf_ctr_i    (buf_if.buf_ctr)    // counter word comes back from the buffer
	);

	rx_sample_buf sample_buf_i (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.wr_i         (wr),
		.wdata_i      (wdata),
		.buf_done_i   (buf_done),
		.bus          (buf_if.buf_mp)
	);

	rx_host_port host_port_i (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.rd_samp_i    (rd_samp_i),
		.rd_ctr_i     (rd_ctr_i),
		.srq_ack_i    (srq_ack_i),
		.rd_valid_o   (rd_valid_o),
		.rd_data_o    (rd_data_o),
		.srq_o        (srq_o),
		.bus          (buf_if.host_mp)
	);

endmodule

// ==== design/rx_host_port.sv ====
////////////////////////////////////////
// host read port
////////////////////////////////////////
`timescale 1ns/1ns

module rx_host_port (
	input  logic          adc_clk,
	input  logic          reset_bufs_A,
	input  logic          rd_samp_i,     // pop one buffer word
	input  logic          rd_ctr_i,      // read the buffer counter
	input  logic          srq_ack_i,
	output logic          rd_valid_o,    // one cycle after either read
	output rx_pkg::word_t rd_data_o,
	output logic          srq_o,         // level, a buffer is ready
	rx_buf_if.host_mp     bus
);
	import rx_pkg::*;

	logic     ctr_sel;    // pending read is a counter read
	buf_ctr_t ctr_q;

	// counter read wins, the sample word stays in the buffer
	assign bus.rd_en = rd_samp_i && !rd_ctr_i;

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			rd_valid_o <= 1'b0;
			srq_o      <= 1'b0;
		end
		else
		begin
			rd_valid_o <= rd_samp_i || rd_ctr_i;
			if (bus.buf_done)
				srq_o <= 1'b1;         // set beats ack
			else if (srq_ack_i)
				srq_o <= 1'b0;
		end
	end

	// result select and counter snapshot
	always_ff @(posedge adc_clk)
	begin
		ctr_sel <= rd_ctr_i;
		if (rd_ctr_i)
			ctr_q <= bus.buf_ctr;
	end

	assign rd_data_o = ctr_sel ? ctr_q : bus.rd_word;

endmodule

// ==== design/rx_sample_buf.sv ====
////////////////////////////////////////
// shared sample buffer
////////////////////////////////////////
`timescale 1ns/1ns

module rx_sample_buf (
	input  logic          adc_clk,
	input  logic          reset_bufs_A,
	input  logic          wr_i,          // one word per high cycle
	input  rx_pkg::word_t wdata_i,
	input  logic          buf_done_i,    // from the sequencer
	rx_buf_if.buf_mp      bus
);
	import rx_pkg::*;

	word_t mem [BUF_WORDS];   // 1024 x 16
	addr_t waddr;
	addr_t raddr;

	// pointers just wrap, the host is expected to keep up
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			waddr <= '0;
			raddr <= '0;
		end
		else
		begin
			if (wr_i)
				waddr <= waddr + 1'b1;
			if (bus.rd_en)
				raddr <= raddr + 1'b1;
		end
	end

	////////////////////////////////////////
	// memory, synchronous read

	always_ff @(posedge adc_clk)
	begin
		if (wr_i)
			mem[waddr] <= wdata_i;
		if (bus.rd_en)
			bus.rd_word <= mem[raddr];   // word out one cycle after rd_en
	end

	// completed buffers
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			bus.buf_ctr <= '0;
		else if (buf_done_i)
			bus.buf_ctr <= bus.buf_ctr + 1'b1;
	end

	assign bus.buf_done = buf_done_i;   // host raises srq from this

endmodule

// ==== design/rx_frame_seq.sv ====
////////////////////////////////////////
// audio frame sequencer
////////////////////////////////////////
`timescale 1ns/1ns

module rx_frame_seq (
	input  logic              adc_clk,
	input  logic              reset_bufs_A,
	input  logic              avail_i,       // new channel data, one cycle
	input  rx_pkg::chan_bus_t chan_i,
	input  rx_pkg::ticks_t    ticks_i,
	input  logic              set_nsamps_i,
	input  rx_pkg::nsamps_t   nsamps_i,
	output logic              wr_o,          // one word per high cycle
	output rx_pkg::word_t     wdata_o,
	output logic              buf_done_o,    // cycle after the counter word
	input  rx_pkg::buf_ctr_t  buf_ctr_i      // fed back from the buffer
);
	import rx_pkg::*;

	seq_state_e        state;
	logic              start;          // frame accepted, first word loads next
	logic [CHAN_W-1:0] chan_idx;       // channel of the word on wdata_o
	logic [1:0]        word_idx;       // i, q, iq3 or tick word on wdata_o
	nsamps_t           frame_cnt;      // frames done in this buffer
	nsamps_t           nsamps_q;       // frames per buffer
	chan_bus_t         chan_lat;
	ticks_t            ticks_lat;      // from the most recent accepted strobe

	logic accept;
	logic last_word;
	logic last_chan;
	logic last_tick;
	logic last_frame;

	// pick word w of channel c from the latched bus
	function automatic word_t chan_word(input chan_bus_t cb, input int c, input int w);
		chan_samp_t samp;
		samp = cb[c*SAMP_W +: SAMP_W];
		return samp[w*WORD_W +: WORD_W];
	endfunction

	// timestamp words go low first
	function automatic word_t tick_word(input ticks_t t, input int w);
		return t[w*WORD_W +: WORD_W];
	endfunction

	assign accept     = (state == S_IDLE) && !start && avail_i;   // busy strobes dropped
	assign last_word  = (word_idx == 2'(WORDS_PER_CHAN - 1));
	assign last_chan  = (chan_idx == CHAN_W'(N_CHANS - 1));
	assign last_tick  = (word_idx == 2'(TICK_WORDS - 1));
	assign last_frame = (frame_cnt == nsamps_t'(nsamps_q - 1'b1));

	// a word sits on wdata_o in exactly these states
	assign wr_o       = (state == S_CHAN) || (state == S_TICKS) || (state == S_CTR);
	assign buf_done_o = (state == S_DONE);

	////////////////////////////////////////
	// control

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			state     <= S_IDLE;
			start     <= 1'b0;
			chan_idx  <= '0;
			word_idx  <= '0;
			frame_cnt <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						start    <= 1'b0;
						chan_idx <= '0;
						word_idx <= '0;
						state    <= S_CHAN;     // ch0 i goes out next cycle
					end
					else if (accept)
						start <= 1'b1;
				end
				S_CHAN:
				begin
					if (!last_word)
						word_idx <= word_idx + 1'b1;
					else
					begin
						word_idx <= '0;
						if (!last_chan)
							chan_idx <= chan_idx + 1'b1;
						else
						begin
							chan_idx <= '0;
							if (last_frame)
								state <= S_TICKS;   // keep going, append ticks
							else
							begin
								state     <= S_IDLE;  // wait for the next frame
								frame_cnt <= frame_cnt + 1'b1;
							end
						end
					end
				end
				S_TICKS:
				begin
					if (last_tick)
					begin
						word_idx <= '0;
						state    <= S_CTR;
					end
					else
						word_idx <= word_idx + 1'b1;
				end
				S_CTR:   state <= S_DONE;     // single counter word
				S_DONE:
				begin
					state     <= S_IDLE;
					frame_cnt <= '0;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// data latches and word mux

	always_ff @(posedge adc_clk)
	begin
		if (set_nsamps_i)
			nsamps_q <= nsamps_i;
		if (accept)
		begin
			chan_lat  <= chan_i;
			ticks_lat <= ticks_i;
		end

		// load the word that goes out on the following cycle
		case (state)
			S_IDLE:  wdata_o <= chan_word(chan_lat, 0, 0);
			S_CHAN:
			begin
				if (!last_word)
					wdata_o <= chan_word(chan_lat, int'(chan_idx), int'(word_idx) + 1);
				else if (!last_chan)
					wdata_o <= chan_word(chan_lat, int'(chan_idx) + 1, 0);
				else
					wdata_o <= tick_word(ticks_lat, 0);   // only used on the last frame
			end
			S_TICKS:
			begin
				if (!last_tick)
					wdata_o <= tick_word(ticks_lat, int'(word_idx) + 1);
				else
					wdata_o <= buf_ctr_i;      // count before this buffer's increment
			end
			default: wdata_o <= wdata_o;
		endcase
	end

endmodule

// ==== design/rx_buf_if.sv ====
////////////////////////////////////////
// sample buffer read path
////////////////////////////////////////
`timescale 1ns/1ns

interface rx_buf_if;
	import rx_pkg::*;

	logic     rd_en;        // pop one word, from host port
	word_t    rd_word;      // valid the cycle after rd_en
	buf_ctr_t buf_ctr;      // live completed-buffer count
	logic     buf_done;     // one cycle, buffer just completed

	// buffer side
	modport buf_mp (
		input  rd_en,
		output rd_word,
		output buf_ctr,
		output buf_done
	);

	// host side
	modport host_mp (
		output rd_en,
		input  rd_word,
		input  buf_ctr,
		input  buf_done
	);

endinterface

// ==== design/rx_pkg.sv ====
////////////////////////////////////////
// receiver audio path definitions
////////////////////////////////////////
package rx_pkg;

	////////////////////////////////////////
	// sizes

	localparam int N_CHANS        = 4;      // receiver channels in the bank
	localparam int WORD_W         = 16;     // shared buffer word
	localparam int WORDS_PER_CHAN = 3;      // i, q, iq3
	localparam int TICKS_W        = 48;     // timestamp
	localparam int BUF_AW         = 10;     // 1024 word buffer
	localparam int NSAMPS_W       = 8;      // frames per buffer setting

	localparam int CHAN_W     = $clog2(N_CHANS);   // channel index width
	localparam int TICK_WORDS = TICKS_W / WORD_W;  // timestamp goes out as 3 words
	localparam int BUF_WORDS  = 1 << BUF_AW;
	localparam int SAMP_W     = WORDS_PER_CHAN * WORD_W;

	////////////////////////////////////////
	// vector types

	typedef logic [WORD_W-1:0]           word_t;
	typedef logic [SAMP_W-1:0]           chan_samp_t;  // iq3:q:i, i in low word
	typedef logic [N_CHANS*SAMP_W-1:0]   chan_bus_t;   // ch0 in low bits
	typedef logic [TICKS_W-1:0]          ticks_t;
	typedef logic [BUF_AW-1:0]           addr_t;
	typedef logic [NSAMPS_W-1:0]         nsamps_t;
	typedef logic [WORD_W-1:0]           buf_ctr_t;    // completed buffers

	// sequencer states
	// S_CHAN, S_TICKS and S_CTR are the states in which a word is on the write port
	typedef enum logic [2:0]
	{
		S_IDLE,
		S_CHAN,
		S_TICKS,
		S_CTR,
		S_DONE
	} seq_state_e;

endpackage
